// ==== verif/qos_vectors.txt ====
# op a b flag, all hex; W writes data b to address a
# R reads address a; flag 0 expects b, flag 1 the model value, flag 2 an error
# A requests mask b for a cycles; flag 1 re-requests after each grant
R BC0 00000001 0
R BC4 80000010 0
R BC5 80000010 0
R BC6 80000010 0
R BC7 80000010 0
W BC0 FFFFFFF9 0
R BC0 00000001 0
W BC5 FFFF0020 0
R BC5 C0000020 0
R 7C0 00000000 2
R BE0 00000000 2
R BDF 00000000 0
W BC4 00000002 0
W BC5 C0000002 0
W BC6 40000002 0
W BC7 80000002 0
A 020 F 0
A 010 F 1
W BC0 00000000 0
A 010 F 1
W BC0 00000003 0
A 020 F 1
W BC2 00000000 0
R BC2 00000000 1
R BC1 00000000 1
R BC3 00000000 1
R BC8 00000000 1
R BC9 00000000 1
R BCA 00000000 1
R BCB 00000000 1
W BC0 00000007 0
R BC0 00000003 0
R BC3 00000000 0
R BC2 00000000 0
R BCB 00000000 0

// ==== sim.f ====
rtl/qos_pkg.sv
rtl/qos_csr_regfile.sv
rtl/qos_arbiter.sv
rtl/qos_monitor.sv
rtl/qos_subsystem.sv
verif/tb_clk_gen.sv
verif/tb_qos_subsystem.sv

// ==== Bender.yml ====
package:
  name: qos_subsystem

sources:
  - files:
      - rtl/qos_pkg.sv
      - rtl/qos_csr_regfile.sv
      - rtl/qos_arbiter.sv
      - rtl/qos_monitor.sv
      - rtl/qos_subsystem.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_qos_subsystem.sv

// ==== verif/tb_qos_subsystem.sv ====
// --------------------
// QoS subsystem testbench
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_qos_subsystem;

    localparam int NUM_CORES      = 4;
    localparam int NUM_QOS_LEVELS = 4;
    localparam int SOAK_CYCLES    = 512;

    logic                            clk;
    logic                            rst_n;
    logic                            csr_valid;
    qos_pkg::csr_req_t               csr_req;
    logic                            csr_rsp_valid_o;
    qos_pkg::csr_rsp_t               csr_rsp_o;
    logic [NUM_CORES-1:0]            req;
    logic [NUM_CORES-1:0]            gnt_o;

    // Vector storage and request bookkeeping
    logic [7:0]           vec_op   [$];
    logic [31:0]          vec_a    [$];
    logic [31:0]          vec_b    [$];
    logic [3:0]           vec_flag [$];
    logic                 loaded;
    logic [NUM_CORES-1:0] pending;     // Cores waiting for a grant
    logic [NUM_CORES-1:0] cont_mask;   // Cores that re-request
    logic                 cont_mode;
    logic [31:0]          lcg_state;

    // --------------------
    // Reference model state
    // --------------------
    logic                  m_enable;
    logic                  m_policy;   // 1 is round robin
    logic                  m_rc;       // Counter clear pulse
    qos_pkg::qos_level_t   m_level [NUM_CORES];
    qos_pkg::lat_limit_t   m_limit [NUM_CORES];
    qos_pkg::lat_limit_t   m_wait  [NUM_CORES];
    logic [NUM_CORES-1:0]  m_gnt;
    int                    m_ptr;
    qos_pkg::count_t       m_total;
    qos_pkg::count_t       m_viol;
    qos_pkg::count_t       m_hit [NUM_QOS_LEVELS];
    logic                  exp_valid;
    logic                  exp_err;
    logic [31:0]           exp_rdata;

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    qos_subsystem #(
        .NUM_CORES      (NUM_CORES),
        .NUM_QOS_LEVELS (NUM_QOS_LEVELS)
    ) dut_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .csr_req_valid_i (csr_valid),
        .csr_req_i       (csr_req),
        .csr_rsp_valid_o (csr_rsp_valid_o),
        .csr_rsp_o       (csr_rsp_o),
        .req_i           (req),
        .gnt_o           (gnt_o)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic model_reset();
        m_enable = 1'b1;   // QoS on in strict mode
        m_policy = 1'b0;
        m_rc     = 1'b0;
        m_gnt    = '0;
        m_ptr    = 0;
        m_total  = '0;
        m_viol   = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            m_level[c] = 2'd2;
            m_limit[c] = 16'd16;
            m_wait[c]  = '0;
        end
        for (int l = 0; l < NUM_QOS_LEVELS; l++) begin
            m_hit[l] = '0;
        end
    endtask

    function automatic logic [31:0] model_read_value(input logic [11:0] addr);
        logic [31:0] v;
        v = '0;  // Unmapped reads 0
        if (addr == qos_pkg::CSR_QOS_CONTROL) v = {29'h0, 1'b0, m_policy, m_enable};
        if (addr == qos_pkg::CSR_QOS_STATUS) begin
            v = {16'h0, m_viol[7:0], 5'h0, m_enable, m_policy, |m_viol};
        end
        if (addr == qos_pkg::CSR_QOS_VIOLATIONS) v = m_viol;
        if (addr == qos_pkg::CSR_QOS_REQUESTS) v = m_total;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (addr == qos_pkg::CSR_QOS_CORE_CFG_BASE + qos_pkg::csr_addr_t'(c)) begin
                v = {m_level[c], 14'h0, m_limit[c]};
            end
        end
        for (int l = 0; l < NUM_QOS_LEVELS; l++) begin
            if (addr == qos_pkg::CSR_QOS_HIT_BASE + qos_pkg::csr_addr_t'(l)) v = m_hit[l];
        end
        return v;
    endfunction

    // --------------------
    // Model update at one rising edge
    // --------------------
    task automatic model_clock_edge();
        logic [NUM_CORES-1:0] elig;
        logic [NUM_CORES-1:0] next_gnt;
        logic                 addr_ok;
        logic                 rc_next;
        int                   win;
        int                   idx;
        int                   g;
        elig     = req & ~m_gnt;    // Last winner sits out
        next_gnt = '0;
        win      = -1;
        g        = -1;
        rc_next  = 1'b0;
        addr_ok  = (csr_req.addr >= 12'hBC0) && (csr_req.addr <= 12'hBDF);
        exp_valid = csr_valid;
        if (csr_valid) begin
            exp_err   = !addr_ok;
            exp_rdata = (csr_req.write || !addr_ok) ? '0 : model_read_value(csr_req.addr);
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            if (!m_enable) begin
                if (win < 0 && elig[k]) win = k;           // Lowest index
            end else if (!m_policy) begin
                if (elig[k] && (win < 0 || m_level[k] > m_level[win])) win = k;
            end else begin
                idx = (m_ptr + k) % NUM_CORES;              // Search from pointer
                if (win < 0 && elig[idx]) win = idx;
            end
        end
        if (win >= 0) begin
            next_gnt[win] = 1'b1;
            if (m_enable && m_policy) m_ptr = (win + 1) % NUM_CORES;
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            if (m_gnt[k]) g = k;
        end
        if (m_rc) begin
            m_total = '0;
            m_viol  = '0;
            for (int l = 0; l < NUM_QOS_LEVELS; l++) m_hit[l] = '0;
        end else if (g >= 0) begin
            m_total++;
            if (m_wait[g] > m_limit[g]) m_viol++;
            else m_hit[m_level[g]]++;
        end
        for (int k = 0; k < NUM_CORES; k++) begin
            if (m_gnt[k] || !req[k]) m_wait[k] = '0;
            else if (m_wait[k] != 16'hFFFF) m_wait[k]++;   // Saturates
        end
        if (csr_valid && csr_req.write && addr_ok) begin
            if (csr_req.addr == qos_pkg::CSR_QOS_CONTROL) begin
                m_enable = csr_req.wdata[0];
                m_policy = csr_req.wdata[1];
                rc_next  = csr_req.wdata[2] & ~m_rc;
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                if (csr_req.addr == qos_pkg::CSR_QOS_CORE_CFG_BASE + qos_pkg::csr_addr_t'(c)) begin
                    m_level[c] = csr_req.wdata[31:30];
                    m_limit[c] = csr_req.wdata[15:0];
                end
            end
        end
        m_rc  = rc_next;
        m_gnt = next_gnt;
    endtask

    // One clock cycle with checks and new inputs 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        model_clock_edge();
        #1;
        assert (gnt_o === m_gnt)
            else fail_run($sformatf("mismatch gnt_o: got %h, expected %h", gnt_o, m_gnt));
        assert (csr_rsp_valid_o === exp_valid)
            else fail_run($sformatf("mismatch csr_rsp_valid_o: got %h, expected %h",
                                    csr_rsp_valid_o, exp_valid));
        if (exp_valid) begin
            assert (csr_rsp_o.error === exp_err)
                else fail_run($sformatf("mismatch csr_rsp_o.error: got %h, expected %h",
                                        csr_rsp_o.error, exp_err));
            assert (csr_rsp_o.rdata === exp_rdata)
                else fail_run($sformatf("mismatch csr_rsp_o.rdata: got %h, expected %h",
                                        csr_rsp_o.rdata, exp_rdata));
        end
        if (cont_mode) pending = cont_mask & ~m_gnt;  // Back next cycle
        else pending = pending & ~m_gnt;              // Served cores drop out
        req       = pending;
        csr_valid = 1'b0;
    endtask

    task automatic csr_access(input logic [11:0] addr, input logic write, input logic [31:0] data);
        csr_valid     = 1'b1;
        csr_req.addr  = addr;
        csr_req.write = write;
        csr_req.wdata = data;
        tick();
    endtask

    task automatic check_read_response(input logic [31:0] expected, input logic [3:0] flag);
        if (flag == 4'd2) begin
            assert (csr_rsp_o.error === 1'b1)
                else fail_run($sformatf("mismatch csr_rsp_o.error: got %h, expected %h",
                                        csr_rsp_o.error, 1'b1));
            assert (csr_rsp_o.rdata === 32'h0)
                else fail_run($sformatf("mismatch csr_rsp_o.rdata: got %h, expected %h",
                                        csr_rsp_o.rdata, 32'h0));
        end else if (flag == 4'd0) begin
            assert (csr_rsp_o.error === 1'b0)
                else fail_run($sformatf("mismatch csr_rsp_o.error: got %h, expected %h",
                                        csr_rsp_o.error, 1'b0));
            assert (csr_rsp_o.rdata === expected)
                else fail_run($sformatf("mismatch csr_rsp_o.rdata: got %h, expected %h",
                                        csr_rsp_o.rdata, expected));
        end
    endtask

    task automatic run_traffic(input int cycles, input logic [NUM_CORES-1:0] mask,
                               input logic cont);
        cont_mode = cont;
        cont_mask = mask;
        pending   = pending | mask;
        req       = pending;
        repeat (cycles) tick();
        cont_mode = 1'b0;  // Leftover requests drain
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  f;
        fd = $fopen("verif/qos_vectors.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open the vector file verif/qos_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%c %h %h %h", op, a, b, f);
                if (n == 4 && op != "#") begin
                    vec_op.push_back(op);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_flag.push_back(f);
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    endtask

    // Random requests plus occasional control and config writes
    task automatic run_soak();
        logic [31:0] r;
        for (int c = 0; c < SOAK_CYCLES; c++) begin
            r = lcg_next();
            if (r[9:8] == 2'd0) pending = pending | r[NUM_CORES-1:0];
            req = pending;
            if (c % 64 == 16) begin
                csr_access(qos_pkg::CSR_QOS_CONTROL, 1'b1, {30'h0, r[17:16]});
            end else if (c % 64 == 48) begin
                csr_access(qos_pkg::CSR_QOS_CORE_CFG_BASE + {10'h0, r[21:20]}, 1'b1,
                           {r[31:30], 26'h0, r[27:24]});
            end else begin
                tick();
            end
        end
    endtask

    // --------------------
    // Watchdog
    // --------------------
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = vec_op.size() * 64 + SOAK_CYCLES + 64;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

    initial begin : main
        csr_valid = 1'b0;
        csr_req   = '0;
        req       = '0;
        pending   = '0;
        cont_mask = '0;
        cont_mode = 1'b0;
        loaded    = 1'b0;
        lcg_state = 32'hc755_2654;
        model_reset();
        load_vectors();
        @(posedge rst_n);
        tick();  // Align to the drive point
        for (int v = 0; v < vec_op.size(); v++) begin
            case (vec_op[v])
                "W": csr_access(vec_a[v][11:0], 1'b1, vec_b[v]);
                "R": begin
                    csr_access(vec_a[v][11:0], 1'b0, '0);
                    check_read_response(vec_b[v], vec_flag[v]);
                end
                "A": run_traffic(int'(vec_a[v]), vec_b[v][NUM_CORES-1:0], vec_flag[v][0]);
                default: fail_run($sformatf("unknown operation %c in the vector file", vec_op[v]));
            endcase
        end
        run_soak();
        repeat (8) tick();
        for (int a = 12'hBC1; a <= 12'hBCB; a++) begin
            csr_access(a[11:0], 1'b0, '0);  // Counters against the model
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// --------------------
// Testbench clock and reset
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/qos_subsystem.sv ====
// --------------------
// QoS subsystem top
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qos_subsystem #(
    parameter int NUM_CORES      = 4,
    parameter int NUM_QOS_LEVELS = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // CSR access
    input  logic                     csr_req_valid_i,
    input  qos_pkg::csr_req_t        csr_req_i,
    output logic                     csr_rsp_valid_o,
    output qos_pkg::csr_rsp_t        csr_rsp_o,
    // Core requests and grants
    input  logic [NUM_CORES-1:0]     req_i,
    output logic [NUM_CORES-1:0]     gnt_o
);

    qos_pkg::qos_ctrl_t                          qos_ctrl;
    qos_pkg::qos_core_cfg_t [NUM_CORES-1:0]      core_cfg;
    logic                   [NUM_CORES-1:0]      gnt;
    qos_pkg::count_t                             violations;
    qos_pkg::count_t                             total_grants;
    qos_pkg::count_t        [NUM_QOS_LEVELS-1:0] hit_counts;

    qos_csr_regfile #(
        .NUM_CORES      (NUM_CORES),
        .NUM_QOS_LEVELS (NUM_QOS_LEVELS)
    ) u_regfile (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .csr_req_valid_i (csr_req_valid_i),
        .csr_req_i       (csr_req_i),
        .csr_rsp_valid_o (csr_rsp_valid_o),
        .csr_rsp_o       (csr_rsp_o),
        .qos_ctrl_o      (qos_ctrl),
        .core_cfg_o      (core_cfg),
        .violations_i    (violations),
        .total_grants_i  (total_grants),
        .hit_counts_i    (hit_counts)
    );

    qos_arbiter #(
        .NUM_CORES (NUM_CORES)
    ) u_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_i      (req_i),
        .qos_ctrl_i (qos_ctrl),
        .core_cfg_i (core_cfg),
        .gnt_o      (gnt)
    );

    qos_monitor #(
        .NUM_CORES      (NUM_CORES),
        .NUM_QOS_LEVELS (NUM_QOS_LEVELS)
    ) u_monitor (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (req_i),
        .gnt_i          (gnt),
        .qos_ctrl_i     (qos_ctrl),
        .core_cfg_i     (core_cfg),
        .violations_o   (violations),
        .total_grants_o (total_grants),
        .hit_counts_o   (hit_counts)
    );

    assign gnt_o = gnt;

endmodule

`default_nettype wire

// ==== rtl/qos_monitor.sv ====
// --------------------
// QoS latency monitor
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qos_monitor #(
    parameter int NUM_CORES      = 4,
    parameter int NUM_QOS_LEVELS = 4
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                   [NUM_CORES-1:0]      req_i,
    input  logic                   [NUM_CORES-1:0]      gnt_i,
    input  qos_pkg::qos_ctrl_t                          qos_ctrl_i,
    input  qos_pkg::qos_core_cfg_t [NUM_CORES-1:0]      core_cfg_i,
    output qos_pkg::count_t                             violations_o,
    output qos_pkg::count_t                             total_grants_o,
    output qos_pkg::count_t        [NUM_QOS_LEVELS-1:0] hit_counts_o
);

    // --------------------
    // Wait timers
    // --------------------
    qos_pkg::lat_limit_t [NUM_CORES-1:0] wait_q;  // Saturating per-core wait

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q <= '0;
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (gnt_i[i] || !req_i[i]) begin
                    wait_q[i] <= '0;                   // Served or idle
                end else if (wait_q[i] != '1) begin
                    wait_q[i] <= wait_q[i] + 1'b1;
                end
            end
        end
    end

    // Granted core's wait, limit and level
    qos_pkg::lat_limit_t gnt_wait;
    qos_pkg::lat_limit_t gnt_limit;
    qos_pkg::qos_level_t gnt_level;

    always_comb begin
        gnt_wait  = '0;
        gnt_limit = '0;
        gnt_level = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (gnt_i[i]) begin
                gnt_wait  = wait_q[i];
                gnt_limit = core_cfg_i[i].latency_limit;
                gnt_level = core_cfg_i[i].level;
            end
        end
    end

    // --------------------
    // Event counters
    // --------------------
    qos_pkg::count_t                      total_q;
    qos_pkg::count_t                      viol_q;
    qos_pkg::count_t [NUM_QOS_LEVELS-1:0] hit_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            total_q <= '0;
            viol_q  <= '0;
            hit_q   <= '0;
        end else if (qos_ctrl_i.reset_counters) begin
            total_q <= '0;  // Software clear
            viol_q  <= '0;
            hit_q   <= '0;
        end else if (|gnt_i) begin
            total_q <= total_q + 1'b1;
            if (gnt_wait > gnt_limit) begin
                viol_q <= viol_q + 1'b1;
            end else begin
                for (int l = 0; l < NUM_QOS_LEVELS; l++) begin
                    if (gnt_level == qos_pkg::qos_level_t'(l)) begin
                        hit_q[l] <= hit_q[l] + 1'b1;  // Met its limit
                    end
                end
            end
        end
    end

    assign violations_o   = viol_q;
    assign total_grants_o = total_q;
    assign hit_counts_o   = hit_q;

    a_total_monotonic: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !qos_ctrl_i.reset_counters |=> (total_q >= $past(total_q)));

endmodule

`default_nettype wire

// ==== rtl/qos_arbiter.sv ====
// --------------------
// QoS grant arbiter
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qos_arbiter #(
    parameter int NUM_CORES = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                   [NUM_CORES-1:0] req_i,
    input  qos_pkg::qos_ctrl_t                     qos_ctrl_i,
    input  qos_pkg::qos_core_cfg_t [NUM_CORES-1:0] core_cfg_i,
    output logic                   [NUM_CORES-1:0] gnt_o
);

    localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    typedef logic [IDX_W-1:0] core_idx_t;

    logic [NUM_CORES-1:0] gnt_q;
    logic [NUM_CORES-1:0] gnt_d;
    logic [NUM_CORES-1:0] req_elig;     // Requests minus last winner
    core_idx_t            rr_ptr_q;     // Round-robin start point
    core_idx_t            win_idx;
    logic                 win_valid;
    qos_pkg::qos_level_t  best_level;
    int                   rr_pos;
    logic                 rr_mode;

    assign req_elig = req_i & ~gnt_q;
    assign rr_mode  = qos_ctrl_i.qos_enable && (qos_ctrl_i.policy == qos_pkg::QOS_ROUND_ROBIN);

    // --------------------
    // Winner select
    // --------------------
    always_comb begin
        win_valid  = 1'b0;
        win_idx    = '0;
        best_level = '0;
        rr_pos     = 0;
        if (!qos_ctrl_i.qos_enable) begin
            // Fixed priority, lowest index wins
            for (int i = NUM_CORES - 1; i >= 0; i--) begin
                if (req_elig[i]) begin
                    win_valid = 1'b1;
                    win_idx   = core_idx_t'(i);
                end
            end
        end else if (!rr_mode) begin
            // Strict: highest level, ties to lowest index
            for (int i = 0; i < NUM_CORES; i++) begin
                if (req_elig[i] && (!win_valid || core_cfg_i[i].level > best_level)) begin
                    win_valid  = 1'b1;
                    win_idx    = core_idx_t'(i);
                    best_level = core_cfg_i[i].level;
                end
            end
        end else begin
            // Scan backwards so the nearest one after the pointer sticks
            for (int k = NUM_CORES - 1; k >= 0; k--) begin
                rr_pos = int'(rr_ptr_q) + k;
                if (rr_pos >= NUM_CORES) begin
                    rr_pos = rr_pos - NUM_CORES;  // Wrap
                end
                if (req_elig[rr_pos]) begin
                    win_valid = 1'b1;
                    win_idx   = core_idx_t'(rr_pos);
                end
            end
        end
        gnt_d = '0;
        if (win_valid) begin
            gnt_d[win_idx] = 1'b1;
        end
    end

    // --------------------
    // Grant and pointer
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_q    <= '0;
            rr_ptr_q <= '0;
        end else begin
            gnt_q <= gnt_d;
            if (win_valid && rr_mode) begin
                // Next search starts after the winner
                rr_ptr_q <= (win_idx == core_idx_t'(NUM_CORES - 1)) ? '0 : win_idx + 1'b1;
            end
        end
    end

    assign gnt_o = gnt_q;

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o));

    // Grant was requested at the sampling edge
    a_gnt_had_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|gnt_o) |-> ((gnt_o & ~$past(req_i)) == '0));

endmodule

`default_nettype wire

// ==== rtl/qos_csr_regfile.sv ====
// --------------------
// QoS CSR register file
// --------------------

`timescale 1ns/1ps
`default_nettype none

module qos_csr_regfile #(
    parameter int NUM_CORES      = 4,
    parameter int NUM_QOS_LEVELS = 4
) (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    // CSR port
    input  logic                                       csr_req_valid_i,
    input  qos_pkg::csr_req_t                          csr_req_i,
    output logic                                       csr_rsp_valid_o,
    output qos_pkg::csr_rsp_t                          csr_rsp_o,
    // Configuration out
    output qos_pkg::qos_ctrl_t                         qos_ctrl_o,
    output qos_pkg::qos_core_cfg_t [NUM_CORES-1:0]     core_cfg_o,
    // Monitor counters in
    input  qos_pkg::count_t                            violations_i,
    input  qos_pkg::count_t                            total_grants_i,
    input  qos_pkg::count_t        [NUM_QOS_LEVELS-1:0] hit_counts_i
);

    // --------------------
    // Decode
    // --------------------
    logic                  addr_in_range;
    logic                  wr_en;
    logic                  rd_en;
    qos_pkg::qos_ctrl_t    wr_ctrl;   // Write data seen as control word
    qos_pkg::qos_core_cfg_t wr_cfg;   // Write data seen as core config

    assign addr_in_range = (csr_req_i.addr >= qos_pkg::CSR_QOS_SPACE_LO) &&
                           (csr_req_i.addr <= qos_pkg::CSR_QOS_SPACE_HI);
    assign wr_en   = csr_req_valid_i && csr_req_i.write && addr_in_range;
    assign rd_en   = csr_req_valid_i && !csr_req_i.write && addr_in_range;
    assign wr_ctrl = qos_pkg::qos_ctrl_t'(csr_req_i.wdata);
    assign wr_cfg  = qos_pkg::qos_core_cfg_t'(csr_req_i.wdata);

    // --------------------
    // Storage
    // --------------------
    qos_pkg::qos_ctrl_t                     ctrl_q;
    qos_pkg::qos_core_cfg_t [NUM_CORES-1:0] cfg_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_q <= qos_pkg::QOS_CTRL_RESET;
            for (int i = 0; i < NUM_CORES; i++) begin
                cfg_q[i] <= qos_pkg::QOS_CORE_CFG_RESET;
            end
        end else begin
            ctrl_q.reset_counters <= 1'b0;  // Pulse lasts one cycle
            if (wr_en && csr_req_i.addr == qos_pkg::CSR_QOS_CONTROL) begin
                ctrl_q.qos_enable     <= wr_ctrl.qos_enable;
                ctrl_q.policy         <= wr_ctrl.policy;
                // Back-to-back set collapses into a single pulse
                ctrl_q.reset_counters <= wr_ctrl.reset_counters & ~ctrl_q.reset_counters;
            end
            for (int i = 0; i < NUM_CORES; i++) begin
                if (wr_en && csr_req_i.addr ==
                        qos_pkg::CSR_QOS_CORE_CFG_BASE + qos_pkg::csr_addr_t'(i)) begin
                    cfg_q[i].level         <= wr_cfg.level;
                    cfg_q[i].latency_limit <= wr_cfg.latency_limit;  // Reserved stays 0
                end
            end
        end
    end

    // --------------------
    // Read mux
    // --------------------
    qos_pkg::word_t     status_word;
    qos_pkg::qos_ctrl_t ctrl_rd;
    qos_pkg::word_t     rdata_d;

    assign status_word = {16'h0,
                          violations_i[7:0],     // Low byte of violation count
                          5'h0,
                          ctrl_q.qos_enable,
                          ctrl_q.policy,
                          |violations_i};        // Any violation

    always_comb begin
        ctrl_rd                = ctrl_q;
        ctrl_rd.reset_counters = 1'b0;  // Always reads 0
        rdata_d                = '0;    // Unmapped in-range reads 0
        case (csr_req_i.addr)
            qos_pkg::CSR_QOS_CONTROL:    rdata_d = ctrl_rd;
            qos_pkg::CSR_QOS_STATUS:     rdata_d = status_word;
            qos_pkg::CSR_QOS_VIOLATIONS: rdata_d = violations_i;
            qos_pkg::CSR_QOS_REQUESTS:   rdata_d = total_grants_i;
            default: begin
                for (int i = 0; i < NUM_CORES; i++) begin
                    if (csr_req_i.addr ==
                            qos_pkg::CSR_QOS_CORE_CFG_BASE + qos_pkg::csr_addr_t'(i)) begin
                        rdata_d = cfg_q[i];
                    end
                end
                for (int l = 0; l < NUM_QOS_LEVELS; l++) begin
                    if (csr_req_i.addr ==
                            qos_pkg::CSR_QOS_HIT_BASE + qos_pkg::csr_addr_t'(l)) begin
                        rdata_d = hit_counts_i[l];
                    end
                end
            end
        endcase
    end

    // --------------------
    // Response
    // --------------------
    logic              rsp_valid_q;
    qos_pkg::csr_rsp_t rsp_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= csr_req_valid_i;  // Every request answered
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_req_valid_i) begin
            rsp_q.error <= !addr_in_range;
            rsp_q.rdata <= rd_en ? rdata_d : '0;  // Writes and errors return 0
        end
    end

    assign csr_rsp_valid_o = rsp_valid_q;
    assign csr_rsp_o       = rsp_q;
    assign qos_ctrl_o      = ctrl_q;
    assign core_cfg_o      = cfg_q;

    // Response only follows a request
    a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_rsp_valid_o |-> $past(csr_req_valid_i));

    // Counter clear is a single-cycle pulse
    a_rst_cnt_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctrl_q.reset_counters |=> !ctrl_q.reset_counters);

endmodule

`default_nettype wire

// ==== rtl/qos_pkg.sv ====
// --------------------
// QoS shared types
// --------------------

`default_nettype none

package qos_pkg;

    // --------------------
    // Widths
    // --------------------
    typedef logic [31:0] word_t;       // CSR data word
    typedef logic [11:0] csr_addr_t;   // CSR address
    typedef logic [1:0]  qos_level_t;  // 3 is highest
    typedef logic [15:0] lat_limit_t;  // Latency limit in cycles
    typedef logic [31:0] count_t;      // Monitor counter

    typedef enum logic {
        QOS_STRICT      = 1'b0,
        QOS_ROUND_ROBIN = 1'b1
    } qos_policy_e;

    // Global control word
    typedef struct packed {
        logic [28:0] reserved;
        logic        reset_counters;  // Self-clearing
        qos_policy_e policy;
        logic        qos_enable;
    } qos_ctrl_t;

    // Per-core configuration word
    typedef struct packed {
        qos_level_t  level;
        logic [13:0] reserved;
        lat_limit_t  latency_limit;
    } qos_core_cfg_t;

    typedef struct packed {
        csr_addr_t addr;
        logic      write;
        word_t     wdata;
    } csr_req_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
    } csr_rsp_t;

    // --------------------
    // CSR address map
    // --------------------
    localparam csr_addr_t CSR_QOS_CONTROL       = 12'hBC0;
    localparam csr_addr_t CSR_QOS_STATUS        = 12'hBC1;
    localparam csr_addr_t CSR_QOS_VIOLATIONS    = 12'hBC2;
    localparam csr_addr_t CSR_QOS_REQUESTS      = 12'hBC3;
    localparam csr_addr_t CSR_QOS_CORE_CFG_BASE = 12'hBC4;  // One word per core
    localparam csr_addr_t CSR_QOS_HIT_BASE      = 12'hBC8;  // One word per level
    localparam csr_addr_t CSR_QOS_SPACE_LO      = 12'hBC0;
    localparam csr_addr_t CSR_QOS_SPACE_HI      = 12'hBDF;

    // Reset defaults
    localparam qos_ctrl_t QOS_CTRL_RESET = '{
        reserved:       '0,
        reset_counters: 1'b0,
        policy:         QOS_STRICT,
        qos_enable:     1'b1
    };
    localparam qos_core_cfg_t QOS_CORE_CFG_RESET = '{
        level:         2'd2,
        reserved:      '0,
        latency_limit: 16'd16
    };

endpackage

`default_nettype wire
